/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_alu_unit
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
+incdir+hw
hw/alu_pkg.sv
hw/exec_if.sv
hw/apb_regs.sv
hw/exec_fsm.sv
hw/step_counter.sv
hw/alu.sv
hw/shift_add_mul.sv
hw/alu_unit_top.sv
testbench/tb_alu_unit.sv

/* hw/alu.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic [3:0]       op,
    output logic [`XLEN-1:0] res,
    output logic             overflow
);
    localparam int MSB = `XLEN - 1;

    logic             sub_sel;
    logic [`XLEN-1:0] b_eff;
    logic [`XLEN:0]   sum;
    logic [`XLEN-1:0] add_res;
    logic             add_of;
    logic             carry;

    // ops that run the adder as a subtractor
    assign sub_sel = (op == `OP_SUB) || (op == `OP_SLT) ||
                     (op == `OP_SLTU) || (op == `OP_NE);

    // shared adder/subtractor
    always_comb begin : add_sub
        b_eff   = sub_sel ? ~b : b;
        sum     = {1'b0, a} + {1'b0, b_eff} + {{`XLEN{1'b0}}, sub_sel};
        add_res = sum[MSB:0];
        carry   = sum[`XLEN];
        add_of  = (a[MSB] == b_eff[MSB]) && (add_res[MSB] != a[MSB]);
    end

    always_comb begin
        overflow = 1'b0;
        res      = '0;
        case (op)
            `OP_ADD: begin
                res      = add_res;
                overflow = add_of;
            end
            `OP_SUB: begin
                res      = add_res;
                overflow = add_of;
            end
            `OP_NEG: res = ~a + 1'b1;                           // two's complement
            `OP_AND: res = a & b;
            `OP_OR:  res = a | b;
            `OP_XOR: res = a ^ b;
            `OP_SLT: begin
                if (a[MSB] != b[MSB]) begin
                    res = {{MSB{1'b0}}, a[MSB]};                // negative a is smaller
                end else begin
                    res = {{MSB{1'b0}}, add_res[MSB]};
                end
            end
            `OP_SLTU: res = {{MSB{1'b0}}, ~carry};              // borrow out
            `OP_NE:   res = {{MSB{1'b0}}, (add_res != '0)};
            `OP_SLL: res = a << b[4:0];
            `OP_SRL: res = a >> b[4:0];
            `OP_SRA: res = $signed(a) >>> b[4:0];               // sign fill
            default: res = '0;                                  // mul and unused codes
        endcase
    end

endmodule

/* hw/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define XLEN            32
`define MUL_STEPS       `XLEN

// opcodes, 4 bits
`define OP_ADD          4'd0
`define OP_SUB          4'd1
`define OP_NEG          4'd2
`define OP_AND          4'd3
`define OP_OR           4'd4
`define OP_XOR          4'd5
`define OP_SLT          4'd6
`define OP_SLTU         4'd7
`define OP_NE           4'd8
`define OP_SLL          4'd9
`define OP_SRL          4'd10
`define OP_SRA          4'd11
`define OP_MUL          4'd12

// apb register offsets
`define REG_OP_A        8'h00
`define REG_OP_B        8'h04
`define REG_CTRL        8'h08
`define REG_STATUS      8'h0C
`define REG_RES_LO      8'h10
`define REG_RES_HI      8'h14

`define CTRL_START_BIT  8
`define ST_BUSY_BIT     0
`define ST_DONE_BIT     1
`define ST_OVF_BIT      2

`endif

/* hw/alu_pkg.sv */
`include "alu_config.svh"

package alu_pkg;

    // 64-bit result, written whole by the engine, read as two words by the regs
    typedef union packed {
        logic [2*`XLEN-1:0] raw;
        struct packed {
            logic [`XLEN-1:0] hi;
            logic [`XLEN-1:0] lo;
        } half;
    } result_t;

endpackage

/* hw/alu_unit_top.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_unit_top
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [`XLEN-1:0]   pwdata,
    output logic [`XLEN-1:0]   prdata,
    output logic               pready,
    output logic               pslverr
);
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [3:0]       alu_op;
    logic [`XLEN-1:0] alu_res;
    logic             alu_of;
    logic             mul_load;
    logic             mul_step;
    logic             cnt_last;
    result_t          product;

    exec_if eif ();

    apb_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctl     (eif.regs)
    );

    exec_fsm u_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .eng      (eif.engine),
        .alu_res  (alu_res),
        .alu_of   (alu_of),
        .op_a     (op_a),
        .op_b     (op_b),
        .alu_op   (alu_op),
        .mul_load (mul_load),
        .mul_step (mul_step),
        .cnt_last (cnt_last),
        .product  (product)
    );

    step_counter u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (mul_load),
        .step  (mul_step),
        .last  (cnt_last)
    );

    alu u_alu (
        .a        (op_a),
        .b        (op_b),
        .op       (alu_op),
        .res      (alu_res),
        .overflow (alu_of)
    );

    shift_add_mul u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (mul_load),
        .step    (mul_step),
        .a       (op_a),
        .b       (op_b),
        .product (product)
    );

endmodule

/* hw/apb_regs.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module apb_regs
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [`XLEN-1:0]   pwdata,
    output logic [`XLEN-1:0]   prdata,
    output logic               pready,
    output logic               pslverr,
    exec_if.regs               ctl
);
    logic [`XLEN-1:0] op_a_q;
    logic [`XLEN-1:0] op_b_q;
    logic [3:0]       op_q;
    logic             start_q;
    logic             access;
    logic             addr_hit;
    logic             addr_ro;
    logic             wr_ok;

    assign access = psel && penable;

    always_comb begin
        addr_hit = 1'b0;
        addr_ro  = 1'b0;
        case (paddr)
            `REG_OP_A, `REG_OP_B, `REG_CTRL: addr_hit = 1'b1;
            `REG_STATUS, `REG_RES_LO, `REG_RES_HI: begin
                addr_hit = 1'b1;
                addr_ro  = 1'b1;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign pready  = 1'b1;                                      // no wait states
    assign pslverr = access && (!addr_hit || (pwrite && addr_ro));
    assign wr_ok   = access && pwrite && !pslverr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_a_q  <= '0;
            op_b_q  <= '0;
            op_q    <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;                                    // pulse
            if (wr_ok) begin
                case (paddr)
                    `REG_OP_A: op_a_q <= pwdata;
                    `REG_OP_B: op_b_q <= pwdata;
                    `REG_CTRL: begin
                        op_q    <= pwdata[3:0];
                        start_q <= pwdata[`CTRL_START_BIT];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign ctl.start = start_q;
    assign ctl.op    = op_q;
    assign ctl.a     = op_a_q;
    assign ctl.b     = op_b_q;

    always_comb begin
        prdata = '0;
        case (paddr)
            `REG_OP_A:   prdata = op_a_q;
            `REG_OP_B:   prdata = op_b_q;
            `REG_CTRL:   prdata[3:0] = op_q;                    // start reads back 0
            `REG_STATUS: begin
                prdata[`ST_BUSY_BIT] = ctl.busy;
                prdata[`ST_DONE_BIT] = ctl.done;
                prdata[`ST_OVF_BIT]  = ctl.overflow;
            end
            `REG_RES_LO: prdata = ctl.result.half.lo;
            `REG_RES_HI: prdata = ctl.result.half.hi;
            default:     prdata = '0;
        endcase
    end

endmodule

/* hw/exec_fsm.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module exec_fsm
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    exec_if.engine             eng,
    input  logic [`XLEN-1:0]   alu_res,
    input  logic               alu_of,
    output logic [`XLEN-1:0]   op_a,
    output logic [`XLEN-1:0]   op_b,
    output logic [3:0]         alu_op,
    output logic               mul_load,
    output logic               mul_step,
    input  logic               cnt_last,
    input  result_t            product
);
    localparam logic S_IDLE = 1'b0;
    localparam logic S_MUL  = 1'b1;

    logic             state;
    logic [`XLEN-1:0] a_q;
    logic [`XLEN-1:0] b_q;
    logic [3:0]       op_q;
    logic [`XLEN-1:0] res_q;
    logic             of_q;
    logic             done_q;
    logic             idle;

    assign idle     = (state == S_IDLE);
    assign mul_load = idle && eng.start && (eng.op == `OP_MUL);
    assign mul_step = (state == S_MUL);

    // alu sees the live operands so its result lands on the start edge
    assign op_a   = idle ? eng.a  : a_q;
    assign op_b   = idle ? eng.b  : b_q;
    assign alu_op = idle ? eng.op : op_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            a_q    <= '0;
            b_q    <= '0;
            op_q   <= '0;
            res_q  <= '0;
            of_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (eng.start) begin
                        a_q  <= eng.a;
                        b_q  <= eng.b;
                        op_q <= eng.op;
                        if (eng.op == `OP_MUL) begin
                            state  <= S_MUL;
                            of_q   <= 1'b0;
                            done_q <= 1'b0;
                        end else begin
                            res_q  <= alu_res;
                            of_q   <= alu_of;
                            done_q <= 1'b1;                     // single cycle op
                        end
                    end
                end
                S_MUL: begin
                    if (cnt_last) begin                         // final step this edge
                        state  <= S_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // product register holds still once the last step is taken
    always_comb begin
        if (op_q == `OP_MUL) begin
            eng.result.raw = product.raw;
        end else begin
            eng.result.raw = {{`XLEN{1'b0}}, res_q};
        end
    end

    assign eng.busy     = (state == S_MUL);
    assign eng.done     = done_q;
    assign eng.overflow = of_q;

endmodule

/* hw/exec_if.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

interface exec_if
    import alu_pkg::*;
();
    logic               start;       // one-cycle pulse
    logic [3:0]         op;
    logic [`XLEN-1:0]   a;
    logic [`XLEN-1:0]   b;
    logic               busy;
    logic               done;        // held until next accepted start
    result_t            result;
    logic               overflow;

    modport regs (
        output start, op, a, b,
        input  busy, done, result, overflow
    );

    modport engine (
        input  start, op, a, b,
        output busy, done, result, overflow
    );

endinterface

/* hw/shift_add_mul.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module shift_add_mul
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic               step,
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    output result_t            product
);
    logic [2*`XLEN-1:0] mcand;                                  // shifts left each step
    logic [`XLEN-1:0]   mplier;                                 // shifts right each step
    result_t            acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcand   <= '0;
            mplier  <= '0;
            acc.raw <= '0;
        end else if (load) begin
            mcand   <= {{`XLEN{1'b0}}, a};
            mplier  <= b;
            acc.raw <= '0;
        end else if (step) begin
            if (mplier[0]) begin
                acc.raw <= acc.raw + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;

endmodule

/* hw/step_counter.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module step_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic step,
    output logic last
);
    localparam int CW = $clog2(`MUL_STEPS + 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= CW'(`MUL_STEPS);
        end else if (step && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    // high on the final step
    assign last = (count == CW'(1));

endmodule

/* testbench/tb_alu_unit.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module tb_alu_unit;
    localparam int CLK_PERIOD = 8;
    localparam int N_EDGE     = 6;
    localparam int N_RAND     = 8;
    localparam int N_MUL      = N_EDGE + 1 + N_RAND;
    localparam int N_OPS      = 15 * (N_EDGE * N_EDGE + N_RAND) + N_MUL + 4;
    localparam int WD_CYCLES  = N_OPS * (`MUL_STEPS + 10) + 2000;
    localparam logic [31:0] START = 32'd1 << `CTRL_START_BIT;
    localparam logic [31:0] EDGE_VAL [N_EDGE] = '{32'h0000_0000, 32'h0000_0001, 32'd31,
                                                  32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    alu_unit_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        $display("CHECKS FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic report_failure(input string msg);
        $display("at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    ready_high: assert property (@(posedge clk) pready === 1'b1)
        else report_mismatch("pready", 32'd1, {31'd0, pready});
    err_in_access: assert property (@(posedge clk) pslverr |-> (psel && penable))
        else report_failure("pslverr raised outside an access cycle");

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err = 1'b0);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);                                      // mid access phase
        check_value($sformatf("pslverr wr@%02h", addr), {31'd0, exp_err}, {31'd0, pslverr});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err = 1'b0);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        data = prdata;
        check_value($sformatf("pslverr rd@%02h", addr), {31'd0, exp_err}, {31'd0, pslverr});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // expected {overflow, result} for the single-cycle opcodes
    function automatic logic [32:0] model_alu(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        logic        of;
        r  = '0;
        of = 1'b0;
        case (op)
            `OP_ADD: begin
                r  = a + b;
                of = (a[31] == b[31]) && (r[31] != a[31]);
            end
            `OP_SUB: begin
                r  = a - b;
                of = (a[31] != b[31]) && (r[31] != a[31]);
            end
            `OP_NEG:  r = 32'd0 - a;
            `OP_AND:  r = a & b;
            `OP_OR:   r = a | b;
            `OP_XOR:  r = a ^ b;
            `OP_SLT:  r = {31'd0, ($signed(a) < $signed(b))};
            `OP_SLTU: r = {31'd0, (a < b)};
            `OP_NE:   r = {31'd0, (a != b)};
            `OP_SLL:  r = a << b[4:0];
            `OP_SRL:  r = a >> b[4:0];
            `OP_SRA:  r = $unsigned($signed(a) >>> b[4:0]);
            default:  r = '0;
        endcase
        return {of, r};
    endfunction

    task automatic run_alu(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b);
        logic [32:0] exp;
        logic [31:0] rd;
        exp = model_alu(op, a, b);
        apb_write(`REG_OP_A, a);
        apb_write(`REG_OP_B, b);
        apb_write(`REG_CTRL, START | {28'd0, op});
        apb_read(`REG_STATUS, rd);                              // first poll must show done
        check_value($sformatf("status op%0d", op), {29'd0, exp[32], 2'b10}, rd);
        apb_read(`REG_RES_LO, rd);
        check_value($sformatf("res_lo op%0d", op), exp[31:0], rd);
        apb_read(`REG_RES_HI, rd);
        check_value($sformatf("res_hi op%0d", op), 32'd0, rd);
    endtask

    task automatic start_mul(input logic [31:0] a, input logic [31:0] b);
        apb_write(`REG_OP_A, a);
        apb_write(`REG_OP_B, b);
        apb_write(`REG_CTRL, START | {28'd0, `OP_MUL});
    endtask

    task automatic wait_mul_done();
        logic [31:0] st;
        int          polls;
        polls = 0;
        do begin
            apb_read(`REG_STATUS, st);
            assert (!(st[`ST_BUSY_BIT] && st[`ST_DONE_BIT]))
                else report_failure("busy and done are set together");
            polls++;
            if (polls > `MUL_STEPS) begin
                report_failure("multiply never reported done");
            end
        end while (!st[`ST_DONE_BIT]);
        check_value("status mul", 32'h2, st);                   // overflow stays clear
    endtask

    task automatic check_product(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] p;
        logic [31:0] rd;
        p = {32'd0, a} * {32'd0, b};
        apb_read(`REG_RES_LO, rd);
        check_value("res_lo mul", p[31:0], rd);
        apb_read(`REG_RES_HI, rd);
        check_value("res_hi mul", p[63:32], rd);
    endtask

    task automatic run_mul(input logic [31:0] a, input logic [31:0] b);
        start_mul(a, b);
        wait_mul_done();
        check_product(a, b);
    endtask

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        report_failure($sformatf("timeout, run not finished after %0d cycles", WD_CYCLES));
    end

    initial begin
        logic [31:0] rd;
        void'($urandom(48938));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        apb_read(`REG_STATUS, rd);
        check_value("status after reset", 32'd0, rd);
        apb_read(`REG_RES_LO, rd);
        check_value("res_lo after reset", 32'd0, rd);
        apb_read(`REG_RES_HI, rd);
        check_value("res_hi after reset", 32'd0, rd);
        apb_read(`REG_OP_A, rd);
        check_value("op_a after reset", 32'd0, rd);

        for (int op = 0; op < 16; op++) begin
            if (op == `OP_MUL) begin
                continue;
            end
            for (int i = 0; i < N_EDGE; i++) begin
                for (int j = 0; j < N_EDGE; j++) begin
                    run_alu(4'(op), EDGE_VAL[i], EDGE_VAL[j]);
                end
            end
            repeat (N_RAND) run_alu(4'(op), $urandom, $urandom);
        end

        for (int i = 0; i < N_EDGE; i++) begin
            run_mul(EDGE_VAL[i], EDGE_VAL[N_EDGE - 1 - i]);
        end
        run_mul(32'hffff_ffff, 32'hffff_ffff);
        repeat (N_RAND) run_mul($urandom, $urandom);

        // new operands and a second start while the first multiply runs
        start_mul(32'hdead_beef, 32'h1234_5678);
        apb_read(`REG_STATUS, rd);
        check_value("status busy", 32'h1, rd);
        apb_write(`REG_OP_A, 32'h1111_1111);
        apb_write(`REG_OP_B, 32'h2222_2222);
        apb_write(`REG_CTRL, START | {28'd0, `OP_MUL});
        wait_mul_done();
        check_product(32'hdead_beef, 32'h1234_5678);
        repeat (3) begin                                        // no second run follows
            apb_read(`REG_STATUS, rd);
            check_value("status after done", 32'h2, rd);
        end

        apb_write(`REG_STATUS, 32'hffff_ffff, 1'b1);
        apb_write(`REG_RES_LO, 32'hffff_ffff, 1'b1);
        apb_write(`REG_RES_HI, 32'hffff_ffff, 1'b1);
        apb_write(8'h18, 32'h5555_5555, 1'b1);
        apb_write(8'h02, 32'h5555_5555, 1'b1);                  // misaligned
        apb_read(8'h18, rd, 1'b1);
        apb_read(8'hfc, rd, 1'b1);
        apb_read(`REG_OP_A, rd);
        check_value("op_a kept", 32'h1111_1111, rd);
        apb_read(`REG_OP_B, rd);
        check_value("op_b kept", 32'h2222_2222, rd);
        apb_read(`REG_CTRL, rd);
        check_value("ctrl kept", {28'd0, `OP_MUL}, rd);
        apb_read(`REG_STATUS, rd);
        check_value("status kept", 32'h2, rd);
        check_product(32'hdead_beef, 32'h1234_5678);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
